//--- logic/int_exec_consts.svh
`ifndef INT_EXEC_CONSTS_SVH
`define INT_EXEC_CONSTS_SVH

// datapath word, RV32I integer registers
`define WORD_WIDTH 32

// instruction address width
`define ADDR_WIDTH 32

// reorder-buffer index, 64 entries
`define ROB_ID_WIDTH 6

// shift amount taken from the low bits of the second operand
`define SHAMT_WIDTH 5

// link address step, no compressed instructions
`define PC_INCR 4

`endif

//--- logic/int_exec_pkg.sv
`include "int_exec_consts.svh"

package int_exec_pkg;

    // plain vector types, sized from the consts header
    typedef logic [`WORD_WIDTH-1:0] word_t; // generic alu word
    typedef logic [`WORD_WIDTH-1:0] reg_data_t; // register-file value
    typedef logic [`WORD_WIDTH-1:0] imm_t; // sign-extended immediate
    typedef logic [`ADDR_WIDTH-1:0] addr_t; // pc / npc
    typedef logic [`ROB_ID_WIDTH-1:0] rob_id_t; // rob entry index
    typedef logic [`SHAMT_WIDTH-1:0] shamt_t; // shift amount

    // one-hot writeback select, msb first
    // [9] sum, [8] sll, [7] srl, [6] sra, [5] sltu,
    // [4] slt, [3] and, [2] or, [1] xor, [0] link
    typedef logic [9:0] dst_sel_t;

    // one-hot branch condition, msb first
    // [5] eq, [4] ne, [3] lt, [2] ge, [1] ltu, [0] geu
    typedef logic [5:0] br_cond_t;

endpackage

//--- logic/int_exec_ctrl.sv
module int_exec_ctrl (
    input  logic                   issue_valid,
    input  logic [2:0]             funct3,
    input  logic                   is_r_type,
    input  logic                   is_i_type,
    input  logic                   is_u_type, // lui / auipc
    input  logic                   is_b_type,
    input  logic                   is_j_type, // jal
    input  logic                   is_sub,
    input  logic                   is_sra_srai,
    input  logic                   is_lui,
    input  logic                   is_jalr,
    output logic                   op1_use_src1,
    output logic                   op1_use_zero,
    output logic                   op2_use_imm,
    output logic                   op2_negate,
    output int_exec_pkg::dst_sel_t dst_sel,
    output int_exec_pkg::br_cond_t br_cond,
    output logic                   npc_lsb_clear,
    output logic                   force_mispred,
    output logic                   dst_valid_next,
    output logic                   br_wb_valid_next
);

    logic [7:0] f3_dec; // funct3 as a one-hot
    logic       alu_en; // funct3 picks the alu op

    assign f3_dec = 8'b1 << funct3;

    // u-type, jal and jalr ignore funct3 so the result select stays one-hot
    assign alu_en = (is_r_type | is_i_type) & ~is_jalr;

    // adder operands
    // R and I (incl. jalr) add to src1, lui adds to zero, the rest to pc
    assign op1_use_src1 = is_r_type | is_i_type;
    assign op1_use_zero = is_u_type & is_lui;
    assign op2_use_imm  = is_i_type; // also steers compare, logic and shift
    assign op2_negate   = is_r_type & is_sub; // sub only

    // result select
    logic sel_sum, sel_sll, sel_srl, sel_sra, sel_sltu;
    logic sel_slt, sel_and, sel_or, sel_xor, sel_link;

    assign sel_sum  = is_u_type | (alu_en & f3_dec[0]); // add/sub/addi, lui, auipc
    assign sel_sll  = alu_en & f3_dec[1];
    assign sel_srl  = alu_en & f3_dec[5] & ~is_sra_srai;
    assign sel_sra  = alu_en & f3_dec[5] & is_sra_srai;
    assign sel_sltu = alu_en & f3_dec[3];
    assign sel_slt  = alu_en & f3_dec[2];
    assign sel_and  = alu_en & f3_dec[7];
    assign sel_or   = alu_en & f3_dec[6];
    assign sel_xor  = alu_en & f3_dec[4];
    assign sel_link = is_j_type | is_jalr; // pc + 4 for both jumps

    assign dst_sel = {sel_sum, sel_sll, sel_srl, sel_sra, sel_sltu,
                      sel_slt, sel_and, sel_or, sel_xor, sel_link};

    // branch condition, zero for anything but B-type
    // beq 000, bne 001, blt 100, bge 101, bltu 110, bgeu 111
    assign br_cond = {6{is_b_type}} &
                     {f3_dec[0], f3_dec[1], f3_dec[4], f3_dec[5], f3_dec[6], f3_dec[7]};

    // jalr target is always a redirect, lsb dropped per spec
    assign npc_lsb_clear = is_jalr;
    assign force_mispred = is_jalr;

    assign dst_valid_next   = issue_valid & ~is_b_type; // branches write no register
    assign br_wb_valid_next = issue_valid & (is_b_type | is_jalr); // jal resolved at fetch

    always_comb begin
        if (dst_valid_next) begin
            assert ($onehot(dst_sel))
                else $error("dst_sel not one-hot for a writing instruction");
        end
        if (issue_valid && is_b_type) begin
            assert ($onehot(br_cond))
                else $error("br_cond not one-hot for an issued branch");
        end
    end

endmodule

//--- logic/int_adder_cmp.sv
`include "int_exec_consts.svh"

module int_adder_cmp (
    input  int_exec_pkg::reg_data_t src1,
    input  int_exec_pkg::reg_data_t src2,
    input  int_exec_pkg::imm_t      imm,
    input  int_exec_pkg::addr_t     pc,
    input  logic                    op1_use_src1,
    input  logic                    op1_use_zero,
    input  logic                    op2_use_imm,
    input  logic                    op2_negate,
    output int_exec_pkg::word_t     sum,
    output int_exec_pkg::addr_t     link,
    output logic                    eq,
    output logic                    ltu,
    output logic                    geu,
    output logic                    lt,
    output logic                    ge
);

    import int_exec_pkg::*;

    word_t add_a;    // src1 | 0 | pc
    word_t add_b;    // imm | src2 | -src2
    word_t neg_src2;
    word_t cmp_b;    // compare operand against src1
    logic  add_imm;

    assign neg_src2 = ~src2 + `WORD_WIDTH'd1; // two's complement for sub

    // first operand
    assign add_a = op1_use_src1 ? src1 :
                   op1_use_zero ? '0 :
                   pc; // auipc, jal and branch target

    // pc- and zero-based forms always add the immediate
    assign add_imm = op2_use_imm | ~op1_use_src1;

    assign add_b = add_imm    ? imm :
                   op2_negate ? neg_src2 :
                   src2;

    assign sum = add_a + add_b;

    // link address for jal / jalr
    assign link = pc + `ADDR_WIDTH'(`PC_INCR);

    // compare src1 against imm for slti/sltiu, src2 for R-type and branches
    assign cmp_b = op2_use_imm ? imm : src2;

    assign eq  = (src1 == cmp_b);
    assign ltu = (src1 < cmp_b);
    assign geu = ~ltu;
    assign lt  = ($signed(src1) < $signed(cmp_b)); // two's complement order
    assign ge  = ~lt;

endmodule

//--- logic/int_logic_shift.sv
`include "int_exec_consts.svh"

module int_logic_shift (
    input  int_exec_pkg::reg_data_t src1,
    input  int_exec_pkg::reg_data_t src2,
    input  int_exec_pkg::imm_t      imm,
    input  logic                    op2_use_imm,
    output int_exec_pkg::word_t     and_out,
    output int_exec_pkg::word_t     or_out,
    output int_exec_pkg::word_t     xor_out,
    output int_exec_pkg::word_t     sll_out,
    output int_exec_pkg::word_t     srl_out,
    output int_exec_pkg::word_t     sra_out
);

    import int_exec_pkg::*;

    word_t  op_b;  // imm for I-type, src2 for R-type
    shamt_t shamt;

    assign op_b = op2_use_imm ? imm : src2;

    // only the low bits shift, upper imm bits carry the srai marker
    assign shamt = op_b[`SHAMT_WIDTH-1:0];

    // bitwise ops
    assign and_out = src1 & op_b;
    assign or_out  = src1 | op_b;
    assign xor_out = src1 ^ op_b;

    // shifts
    assign sll_out = src1 << shamt;
    assign srl_out = src1 >> shamt; // zero fill

    // sign fill from src1 msb
    assign sra_out = $signed(src1) >>> shamt;

endmodule

//--- logic/int_branch_resolve.sv
module int_branch_resolve (
    input  int_exec_pkg::br_cond_t br_cond,
    input  logic                   eq,
    input  logic                   lt,
    input  logic                   ge,
    input  logic                   ltu,
    input  logic                   geu,
    input  int_exec_pkg::word_t    sum,           // pc + imm or src1 + imm
    input  logic                   npc_lsb_clear, // jalr
    input  logic                   force_mispred, // jalr
    input  logic                   br_dir_pred,   // 1 = predicted taken
    output logic                   br_taken,
    output int_exec_pkg::addr_t    npc,
    output logic                   mispred
);

    import int_exec_pkg::*;

    br_cond_t cond_met; // each condition evaluated in parallel

    // same bit order as br_cond
    assign cond_met = {eq,  // beq
                       ~eq, // bne
                       lt,  // blt
                       ge,  // bge
                       ltu, // bltu
                       geu}; // bgeu

    // one-hot and-or pick, zero when no branch condition is selected
    assign br_taken = |(br_cond & cond_met);

    // branch target or jalr target
    // jalr drops bit 0, branch targets are already even
    assign npc = {sum[$bits(addr_t)-1:1], sum[0] & ~npc_lsb_clear};

    // direction mismatch, or any jalr since its target is never predicted here
    assign mispred = (br_dir_pred ^ br_taken) | force_mispred;

endmodule

//--- logic/int_result_stage.sv
`include "int_exec_consts.svh"

module int_result_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    issue_valid,
    input  int_exec_pkg::dst_sel_t  dst_sel,
    input  int_exec_pkg::word_t     sum,
    input  int_exec_pkg::addr_t     link,
    input  logic                    ltu,
    input  logic                    lt,
    input  int_exec_pkg::word_t     and_out,
    input  int_exec_pkg::word_t     or_out,
    input  int_exec_pkg::word_t     xor_out,
    input  int_exec_pkg::word_t     sll_out,
    input  int_exec_pkg::word_t     srl_out,
    input  int_exec_pkg::word_t     sra_out,
    input  int_exec_pkg::addr_t     npc,
    input  logic                    mispred,
    input  logic                    dst_valid_next,
    input  logic                    br_wb_valid_next,
    input  int_exec_pkg::rob_id_t   instr_rob_id_in,
    output logic                    wb_valid,
    output logic                    dst_valid,
    output int_exec_pkg::reg_data_t dst,
    output logic                    br_wb_valid,
    output int_exec_pkg::addr_t     npc_out,
    output logic                    br_mispred,
    output int_exec_pkg::rob_id_t   instr_rob_id_out
);

    import int_exec_pkg::*;

    word_t ltu_ext; // sltu / sltiu result
    word_t lt_ext;  // slt / slti result
    word_t dst_next;

    assign ltu_ext = {{(`WORD_WIDTH-1){1'b0}}, ltu};
    assign lt_ext  = {{(`WORD_WIDTH-1){1'b0}}, lt};

    // and-or mux that relies on a one-hot dst_sel
    assign dst_next = ({`WORD_WIDTH{dst_sel[9]}} & sum)
                    | ({`WORD_WIDTH{dst_sel[8]}} & sll_out)
                    | ({`WORD_WIDTH{dst_sel[7]}} & srl_out)
                    | ({`WORD_WIDTH{dst_sel[6]}} & sra_out)
                    | ({`WORD_WIDTH{dst_sel[5]}} & ltu_ext)
                    | ({`WORD_WIDTH{dst_sel[4]}} & lt_ext)
                    | ({`WORD_WIDTH{dst_sel[3]}} & and_out)
                    | ({`WORD_WIDTH{dst_sel[2]}} & or_out)
                    | ({`WORD_WIDTH{dst_sel[1]}} & xor_out)
                    | ({`WORD_WIDTH{dst_sel[0]}} & link);

    // writeback control
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid    <= 1'b0;
            dst_valid   <= 1'b0;
            br_wb_valid <= 1'b0;
            br_mispred  <= 1'b0;
        end else begin
            wb_valid    <= issue_valid;
            dst_valid   <= dst_valid_next;
            br_wb_valid <= br_wb_valid_next;
            br_mispred  <= br_wb_valid_next & mispred; // low unless resolving
        end
    end

    // payload registers qualified by the valids above
    always_ff @(posedge clk) begin
        dst              <= dst_next;
        npc_out          <= npc;
        instr_rob_id_out <= instr_rob_id_in;
    end

    // rob writes only ride along with a writeback slot
    a_valids_need_wb: assert property (@(posedge clk) disable iff (reset)
        (dst_valid || br_wb_valid) |-> wb_valid)
        else $error("dst_valid or br_wb_valid without wb_valid");

endmodule

//--- logic/int_execute_unit.sv
module int_execute_unit (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    issue_valid,
    input  int_exec_pkg::reg_data_t src1,
    input  int_exec_pkg::reg_data_t src2,
    input  int_exec_pkg::imm_t      imm,
    input  int_exec_pkg::addr_t     pc,
    input  logic [2:0]              funct3,
    input  logic                    is_r_type,
    input  logic                    is_i_type,
    input  logic                    is_u_type,
    input  logic                    is_b_type,
    input  logic                    is_j_type,
    input  logic                    is_sub,
    input  logic                    is_sra_srai,
    input  logic                    is_lui,
    input  logic                    is_jalr,
    input  int_exec_pkg::rob_id_t   instr_rob_id_in,
    input  logic                    br_dir_pred,
    output logic                    wb_valid,
    output int_exec_pkg::rob_id_t   instr_rob_id_out,
    output logic                    dst_valid,
    output int_exec_pkg::reg_data_t dst,
    output logic                    br_wb_valid,
    output int_exec_pkg::addr_t     npc,
    output logic                    br_mispred
);

    import int_exec_pkg::*;

    // control to datapath
    logic     op1_use_src1, op1_use_zero, op2_use_imm, op2_negate;
    dst_sel_t dst_sel;
    br_cond_t br_cond;
    logic     npc_lsb_clear, force_mispred;
    logic     dst_valid_next, br_wb_valid_next;

    // datapath results
    word_t sum;
    addr_t link;
    logic  eq, ltu, geu, lt, ge;
    word_t and_out, or_out, xor_out, sll_out, srl_out, sra_out;
    addr_t npc_next;
    logic  mispred;

    int_exec_ctrl i_ctrl (
        .issue_valid(issue_valid), .funct3(funct3),
        .is_r_type(is_r_type), .is_i_type(is_i_type), .is_u_type(is_u_type),
        .is_b_type(is_b_type), .is_j_type(is_j_type), .is_sub(is_sub),
        .is_sra_srai(is_sra_srai), .is_lui(is_lui), .is_jalr(is_jalr),
        .op1_use_src1(op1_use_src1), .op1_use_zero(op1_use_zero),
        .op2_use_imm(op2_use_imm), .op2_negate(op2_negate),
        .dst_sel(dst_sel), .br_cond(br_cond),
        .npc_lsb_clear(npc_lsb_clear), .force_mispred(force_mispred),
        .dst_valid_next(dst_valid_next), .br_wb_valid_next(br_wb_valid_next)
    );

    int_adder_cmp i_adder_cmp (
        .src1(src1), .src2(src2), .imm(imm), .pc(pc),
        .op1_use_src1(op1_use_src1), .op1_use_zero(op1_use_zero),
        .op2_use_imm(op2_use_imm), .op2_negate(op2_negate),
        .sum(sum), .link(link),
        .eq(eq), .ltu(ltu), .geu(geu), .lt(lt), .ge(ge)
    );

    int_logic_shift i_logic_shift (
        .src1(src1), .src2(src2), .imm(imm), .op2_use_imm(op2_use_imm),
        .and_out(and_out), .or_out(or_out), .xor_out(xor_out),
        .sll_out(sll_out), .srl_out(srl_out), .sra_out(sra_out)
    );

    // taken bit itself stays local, the rob only needs mispred
    int_branch_resolve i_branch_resolve (
        .br_cond(br_cond), .eq(eq), .lt(lt), .ge(ge), .ltu(ltu), .geu(geu),
        .sum(sum), .npc_lsb_clear(npc_lsb_clear), .force_mispred(force_mispred),
        .br_dir_pred(br_dir_pred), .br_taken(), .npc(npc_next), .mispred(mispred)
    );

    int_result_stage i_result_stage (
        .clk(clk), .reset(reset), .issue_valid(issue_valid), .dst_sel(dst_sel),
        .sum(sum), .link(link), .ltu(ltu), .lt(lt),
        .and_out(and_out), .or_out(or_out), .xor_out(xor_out),
        .sll_out(sll_out), .srl_out(srl_out), .sra_out(sra_out),
        .npc(npc_next), .mispred(mispred),
        .dst_valid_next(dst_valid_next), .br_wb_valid_next(br_wb_valid_next),
        .instr_rob_id_in(instr_rob_id_in),
        .wb_valid(wb_valid), .dst_valid(dst_valid), .dst(dst),
        .br_wb_valid(br_wb_valid), .npc_out(npc), .br_mispred(br_mispred),
        .instr_rob_id_out(instr_rob_id_out)
    );

    // a resolving conditional branch must reach branch_resolve with a condition
    a_branch_has_cond: assert property (@(posedge clk) disable iff (reset)
        (br_wb_valid_next && !force_mispred) |-> (br_cond != '0))
        else $error("resolving branch with no condition selected");

endmodule

//--- tests/int_execute_unit_tb.sv
module int_execute_unit_tb;

    import int_exec_pkg::*;

    localparam int NUM_TESTS   = 3000;
    localparam int IDLE_CYCLES = 4;  // quiet slots right after reset
    localparam int CLK_PERIOD  = 4;
    localparam int TIMEOUT     = (NUM_TESTS + IDLE_CYCLES + 8) * CLK_PERIOD + 200;

    logic      clk, reset, issue_valid;
    reg_data_t src1, src2;
    imm_t      imm;
    addr_t     pc;
    logic [2:0] funct3;
    logic      is_r_type, is_i_type, is_u_type, is_b_type, is_j_type;
    logic      is_sub, is_sra_srai, is_lui, is_jalr;
    rob_id_t   instr_rob_id_in;
    logic      br_dir_pred;
    logic      wb_valid, dst_valid, br_wb_valid, br_mispred;
    rob_id_t   instr_rob_id_out;
    reg_data_t dst;
    addr_t     npc;

    logic [31:0] lfsr_state;

    // model output for the instruction now in the writeback register
    logic    exp_wb_valid, exp_dst_valid, exp_br_wb_valid, exp_mispred;
    word_t   exp_dst;
    addr_t   exp_npc;
    rob_id_t exp_rob_id;

    int_execute_unit i_dut (
        .clk(clk), .reset(reset), .issue_valid(issue_valid),
        .src1(src1), .src2(src2), .imm(imm), .pc(pc), .funct3(funct3),
        .is_r_type(is_r_type), .is_i_type(is_i_type), .is_u_type(is_u_type),
        .is_b_type(is_b_type), .is_j_type(is_j_type), .is_sub(is_sub),
        .is_sra_srai(is_sra_srai), .is_lui(is_lui), .is_jalr(is_jalr),
        .instr_rob_id_in(instr_rob_id_in), .br_dir_pred(br_dir_pred),
        .wb_valid(wb_valid), .instr_rob_id_out(instr_rob_id_out),
        .dst_valid(dst_valid), .dst(dst), .br_wb_valid(br_wb_valid),
        .npc(npc), .br_mispred(br_mispred)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // hard stop in case the stimulus loop stalls
    initial begin
        #(TIMEOUT);
        $display("timeout: test loop did not finish within %0d time units", TIMEOUT);
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

    // galois lfsr stepped once per bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            if (lfsr_state[0])
                lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
            else
                lfsr_state = lfsr_state >> 1;
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAILED t=%0t %s expected %h actual %h", $time, name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "output mismatch");
        end
    endtask

    // payload is meaningful only while its valid is high
    task automatic check_writeback();
        compare_value("wb_valid", 32'(exp_wb_valid), 32'(wb_valid));
        compare_value("dst_valid", 32'(exp_dst_valid), 32'(dst_valid));
        compare_value("br_wb_valid", 32'(exp_br_wb_valid), 32'(br_wb_valid));
        compare_value("br_mispred", 32'(exp_mispred), 32'(br_mispred));
        if (exp_wb_valid)
            compare_value("instr_rob_id_out", 32'(exp_rob_id), 32'(instr_rob_id_out));
        if (exp_dst_valid)
            compare_value("dst", exp_dst, dst);
        if (exp_br_wb_valid)
            compare_value("npc", exp_npc, npc);
    endtask

    // kind 0-9 is R alu, 10-18 I alu, 19 lui, 20 auipc, 21 jal, 22 jalr, 23-28 branches
    task automatic drive_instr(input logic active);
        logic [31:0] r;
        int          kind;
        logic [2:0]  f3;
        logic        writes, resolves, taken;
        word_t       op2, res;
        addr_t       tgt;

        {is_r_type, is_i_type, is_u_type, is_b_type, is_j_type} = 5'b0;
        {is_sub, is_sra_srai, is_lui, is_jalr} = 4'b0;
        issue_valid     = active;
        src1            = take_bits(32);
        src2            = (take_bits(2) == 0) ? src1 : take_bits(32); // eq now and then
        pc              = take_bits(30) << 2;
        instr_rob_id_in = rob_id_t'(take_bits(6));
        br_dir_pred     = take_bits(1) != 0;
        funct3          = 3'(take_bits(3)); // U and J carry imm bits in this field
        kind            = int'(take_bits(5) % 29);
        r               = take_bits(12);
        imm             = {{20{r[11]}}, r[11:0]}; // I-type form by default
        f3 = 3'd0;
        writes = 1'b1;
        resolves = 1'b0;
        taken = 1'b0;
        res = '0;
        tgt = '0;

        if (kind < 10) begin
            is_r_type   = 1'b1;
            is_sub      = (kind == 1);
            is_sra_srai = (kind == 7);
            case (kind)
                0, 1: f3 = 3'd0; // add, sub
                2: f3 = 3'd1;    // sll
                3: f3 = 3'd2;    // slt
                4: f3 = 3'd3;    // sltu
                5: f3 = 3'd4;    // xor
                6, 7: f3 = 3'd5; // srl, sra
                8: f3 = 3'd6;    // or
                default: f3 = 3'd7;
            endcase
        end else if (kind < 19) begin
            is_i_type   = 1'b1;
            is_sra_srai = (kind == 18);
            case (kind)
                10: f3 = 3'd0; // addi
                11: f3 = 3'd2; // slti
                12: f3 = 3'd3; // sltiu
                13: f3 = 3'd4; // xori
                14: f3 = 3'd6; // ori
                15: f3 = 3'd7; // andi
                16: f3 = 3'd1; // slli
                default: f3 = 3'd5;
            endcase
            if (kind >= 16) begin
                r   = take_bits(5);
                imm = {21'b0, is_sra_srai, 5'b0, r[4:0]}; // imm[10] marks srai
            end
        end

        if (kind < 19) begin
            funct3 = f3;
            op2 = is_i_type ? imm : src2;
            case (f3)
                3'd0: res = is_sub ? src1 - op2 : src1 + op2;
                3'd1: res = src1 << op2[4:0];
                3'd2: res = ($signed(src1) < $signed(op2)) ? 32'd1 : 32'd0;
                3'd3: res = (src1 < op2) ? 32'd1 : 32'd0;
                3'd4: res = src1 ^ op2;
                3'd5: res = is_sra_srai ? word_t'($signed(src1) >>> op2[4:0])
                                        : src1 >> op2[4:0];
                3'd6: res = src1 | op2;
                default: res = src1 & op2;
            endcase
        end else if (kind == 19 || kind == 20) begin
            is_u_type = 1'b1;
            is_lui    = (kind == 19);
            imm       = take_bits(20) << 12;
            res       = is_lui ? imm : pc + imm;
        end else if (kind == 21) begin
            is_j_type = 1'b1;
            r         = take_bits(20);
            imm       = {{11{r[19]}}, r[19:0], 1'b0};
            res       = pc + 32'd4;
        end else if (kind == 22) begin
            is_i_type = 1'b1;
            is_jalr   = 1'b1;
            funct3    = 3'd0;
            res       = pc + 32'd4;
            tgt       = (src1 + imm) & ~32'd1;
            resolves  = 1'b1;
        end else begin
            is_b_type = 1'b1;
            writes    = 1'b0;
            resolves  = 1'b1;
            r         = take_bits(12);
            imm       = {{19{r[11]}}, r[11:0], 1'b0}; // branch offsets are even
            tgt       = pc + imm;
            // kinds 23 and 24 are beq and bne, 25 to 28 run blt through bgeu
            funct3    = (kind < 25) ? 3'(kind - 23) : 3'(kind - 21);
            case (funct3)
                3'd0: taken = (src1 == src2);                   // beq
                3'd1: taken = (src1 != src2);                   // bne
                3'd4: taken = ($signed(src1) < $signed(src2));  // blt
                3'd5: taken = ($signed(src1) >= $signed(src2)); // bge
                3'd6: taken = (src1 < src2);                    // bltu
                default: taken = (src1 >= src2);                // bgeu
            endcase
        end

        exp_wb_valid    = active;
        exp_dst_valid   = active & writes;
        exp_br_wb_valid = active & resolves;
        exp_mispred     = active & resolves & (is_jalr | (br_dir_pred ^ taken));
        exp_dst         = res;
        exp_npc         = tgt;
        exp_rob_id      = instr_rob_id_in;
    endtask

    initial begin
        reset = 1'b1;
        issue_valid = 1'b0;
        src1 = '0;
        src2 = '0;
        imm = '0;
        pc = '0;
        funct3 = 3'd0;
        {is_r_type, is_i_type, is_u_type, is_b_type, is_j_type} = 5'b0;
        {is_sub, is_sra_srai, is_lui, is_jalr} = 4'b0;
        instr_rob_id_in = '0;
        br_dir_pred = 1'b0;
        lfsr_state = 32'hf1d5;
        {exp_wb_valid, exp_dst_valid, exp_br_wb_valid, exp_mispred} = 4'b0;
        exp_dst = '0;
        exp_npc = '0;
        exp_rob_id = '0;

        repeat (2) @(posedge clk);
        @(negedge clk);
        check_writeback(); // reset must have cleared the valids
        reset = 1'b0;

        // check last slot's writeback and issue the next one
        for (int n = 0; n < IDLE_CYCLES + NUM_TESTS; n++) begin
            @(negedge clk);
            check_writeback();
            drive_instr(n >= IDLE_CYCLES && take_bits(2) != 0);
        end
        @(negedge clk);
        check_writeback(); // drain the final instruction

        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- int_execute_unit.f
+incdir+logic
logic/int_exec_pkg.sv
logic/int_exec_ctrl.sv
logic/int_adder_cmp.sv
logic/int_logic_shift.sv
logic/int_branch_resolve.sv
logic/int_result_stage.sv
logic/int_execute_unit.sv
tests/int_execute_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the execute-unit testbench with verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"
verilator --binary --timing --assert -f int_execute_unit.f \
    --top-module int_execute_unit_tb -o sim_int_execute_unit > "$LOG" 2>&1 &&
    ./obj_dir/sim_int_execute_unit >> "$LOG" 2>&1 ||
    echo "*** FAILED ***" >> "$LOG"
cat "$LOG"
if grep -qF "*** FAILED ***" "$LOG"; then
    echo "simulation failed, see $LOG"
    exit 1
fi
echo "simulation passed"
exit 0
